/* rtl/isa_pkg.sv */
package isa_pkg;

    // machine word
    typedef logic [15:0] word_t;

    // upper nibble of every instruction
    // codes 4'ha to 4'hf execute as nop
    typedef enum logic [3:0] {
        LDA    = 4'h0,
        STA    = 4'h1,
        ADD    = 4'h2,
        SUB    = 4'h3,
        AND_OP = 4'h4,
        LDI    = 4'h5,
        ADI    = 4'h6,
        JMP    = 4'h7,
        JZ     = 4'h8,
        HLT    = 4'h9
    } opcode_e;

    // memory reference and branch format
    typedef struct packed {
        opcode_e     op;
        logic [11:0] addr;
    } mem_fmt_t;

    // immediate format, sign extended before use
    typedef struct packed {
        opcode_e            op;
        logic signed [11:0] imm;
    } imm_fmt_t;

    // one IR word, read either way depending on the opcode
    typedef union packed {
        mem_fmt_t mem;
        imm_fmt_t imm;
    } instr_u;

endpackage

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC,
        WRITEBACK,
        HALT
    } state_e;

    // alu function select
    typedef enum logic [1:0] {
        PASS,
        ADD,
        SUB,
        AND
    } alu_op_e;

    // strobes from the control unit to the datapath
    typedef struct packed {
        logic    ld_ar_pc;
        logic    ld_ar_ir;
        logic    ld_ir;
        logic    inc_pc;
        logic    ld_pc_ir;
        logic    ld_dr;
        logic    ld_ac;
        logic    use_imm;
        logic    wr_mem;
        alu_op_e alu_op;
    } micro_ops_t;

    // core side data memory request
    typedef struct packed {
        logic [15:0]    addr;
        isa_pkg::word_t wdata;
        logic           we;
        logic           re;
    } dmem_req_t;

    // host load port, imem_sel picks the target memory
    typedef struct packed {
        logic           imem_sel;
        logic           we;
        logic [15:0]    addr;
        isa_pkg::word_t data;
    } host_wr_t;

endpackage

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu (
    input  ctrl_pkg::alu_op_e op,
    input  isa_pkg::word_t    a,
    input  isa_pkg::word_t    b,
    output isa_pkg::word_t    y,
    output logic              zero
);

    // a is the accumulator, b the memory word or immediate
    // sums wrap at 16 bits
    always_comb begin
        case (op)
            ctrl_pkg::PASS: begin
                y = b;
            end
            ctrl_pkg::ADD: begin
                y = a + b;
            end
            ctrl_pkg::SUB: begin
                y = a - b;
            end
            ctrl_pkg::AND: begin
                y = a & b;
            end
            default: begin
                y = b;
            end
        endcase
    end

    assign zero = (y == '0);

endmodule

/* rtl/instruction_memory.sv */
`timescale 1ns/10ps

module instruction_memory #(
    parameter int IMEM_AW = 8
) (
    input  logic               clk,
    input  logic               busy,
    input  ctrl_pkg::host_wr_t host_wr,
    input  isa_pkg::word_t     addr,
    output isa_pkg::word_t     rdata
);

    isa_pkg::word_t mem [2**IMEM_AW];

    logic load;

    assign load = host_wr.we && host_wr.imem_sel;

    // program load from the host
    always_ff @(posedge clk) begin
        if (load) begin
            mem[host_wr.addr[IMEM_AW-1:0]] <= host_wr.data;
        end
    end

    // fetch read is asynchronous so IR can load in DECODE
    assign rdata = mem[addr[IMEM_AW-1:0]];

    // program stays fixed while the core runs it
    a_no_load_while_busy: assert property (
        @(posedge clk) busy |-> !load
    ) else $error("instruction memory written while core busy");

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/10ps

module data_memory #(
    parameter int DMEM_AW = 8
) (
    input  logic                clk,
    input  logic                busy,
    input  ctrl_pkg::dmem_req_t core_req,
    input  ctrl_pkg::host_wr_t  host_wr,
    input  isa_pkg::word_t      host_rd_addr,
    output isa_pkg::word_t      rdata
);

    isa_pkg::word_t mem [2**DMEM_AW];

    logic               wr_en;
    logic               rd_en;
    logic [DMEM_AW-1:0] wr_addr;
    logic [DMEM_AW-1:0] rd_addr;
    isa_pkg::word_t     wr_data;

    // core owns the port while busy, host gets it otherwise
    always_comb begin
        if (busy) begin
            wr_en   = core_req.we;
            rd_en   = core_req.re;
            wr_addr = core_req.addr[DMEM_AW-1:0];
            rd_addr = core_req.addr[DMEM_AW-1:0];
            wr_data = core_req.wdata;
        end else begin
            wr_en   = host_wr.we && !host_wr.imem_sel;
            rd_en   = 1'b1;
            wr_addr = host_wr.addr[DMEM_AW-1:0];
            rd_addr = host_rd_addr[DMEM_AW-1:0];
            wr_data = host_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read register, also the host readback
        if (rd_en) begin
            rdata <= mem[rd_addr];
        end
    end

    a_no_rd_wr_same_cycle: assert property (
        @(posedge clk) !(core_req.we && core_req.re)
    ) else $error("core issued read and write in one cycle");

endmodule

/* rtl/datapath.sv */
`timescale 1ns/10ps

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  ctrl_pkg::micro_ops_t uops,
    input  isa_pkg::word_t       imem_rdata,
    input  isa_pkg::word_t       dmem_rdata,
    output isa_pkg::word_t       imem_addr,
    output ctrl_pkg::dmem_req_t  dmem_req,
    output isa_pkg::instr_u      instr,
    output logic                 zero
);

    isa_pkg::word_t  pc;
    isa_pkg::word_t  ar;
    isa_pkg::word_t  ac;
    isa_pkg::instr_u ir;
    isa_pkg::instr_u fetched;
    isa_pkg::word_t  bus;
    isa_pkg::word_t  imm_ext;
    isa_pkg::word_t  b_op;
    isa_pkg::word_t  alu_y;
    logic            alu_zero;
    logic            z_flag;

    assign fetched = imem_rdata;

    // address bus into AR and PC
    always_comb begin
        if (uops.ld_ar_pc) begin
            bus = pc;
        end else if (uops.ld_ar_ir) begin
            // instruction arriving this cycle, so EXEC already has its address
            bus = {4'h0, fetched.mem.addr};
        end else begin
            bus = {4'h0, ir.mem.addr};
        end
    end

    assign imm_ext = {{4{ir.imm.imm[11]}}, ir.imm.imm};
    assign b_op    = uops.use_imm ? imm_ext : dmem_rdata;

    alu i_alu (
        .op   (uops.alu_op),
        .a    (ac),
        .b    (b_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            pc <= '0;
        end else if (uops.ld_pc_ir) begin
            pc <= bus;
        end else if (uops.inc_pc) begin
            pc <= pc + 16'd1;
        end
    end

    // AC cleared means zero flag set
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            ac     <= '0;
            z_flag <= 1'b1;
        end else if (uops.ld_ac) begin
            ac     <= alu_y;
            z_flag <= alu_zero;
        end
    end

    always_ff @(posedge clk) begin
        if (uops.ld_ar_pc || uops.ld_ar_ir) begin
            ar <= bus;
        end
        if (uops.ld_ir) begin
            ir <= fetched;
        end
    end

    assign imem_addr = ar;
    assign instr     = ir;
    assign zero      = z_flag;

    // DR is the registered read inside data memory, ld_dr requests it
    assign dmem_req.addr  = ar;
    assign dmem_req.wdata = ac;
    assign dmem_req.we    = uops.wr_mem;
    assign dmem_req.re    = uops.ld_dr;

endmodule

/* rtl/control_unit.sv */
`timescale 1ns/10ps

module control_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  isa_pkg::instr_u      instr,
    input  logic                 zero,
    output ctrl_pkg::micro_ops_t uops,
    output logic                 clear,
    output logic                 busy,
    output logic                 done
);

    ctrl_pkg::state_e  state;
    ctrl_pkg::state_e  state_nxt;
    isa_pkg::opcode_e  op;
    ctrl_pkg::alu_op_e alu_sel;

    // opcode sits in the same place in both formats
    assign op = instr.mem.op;

    assign busy  = (state != ctrl_pkg::IDLE) && (state != ctrl_pkg::HALT);
    assign done  = (state == ctrl_pkg::HALT);
    assign clear = start && !busy;

    always_comb begin
        case (op)
            isa_pkg::ADD, isa_pkg::ADI: alu_sel = ctrl_pkg::ADD;
            isa_pkg::SUB:               alu_sel = ctrl_pkg::SUB;
            isa_pkg::AND_OP:            alu_sel = ctrl_pkg::AND;
            default:                    alu_sel = ctrl_pkg::PASS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ctrl_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        uops        = '0;
        uops.alu_op = alu_sel;
        state_nxt   = state;
        case (state)
            ctrl_pkg::IDLE, ctrl_pkg::HALT: begin
                if (start) begin
                    state_nxt = ctrl_pkg::FETCH;
                end
            end
            ctrl_pkg::FETCH: begin
                uops.ld_ar_pc = 1'b1;
                state_nxt     = ctrl_pkg::DECODE;
            end
            ctrl_pkg::DECODE: begin
                uops.ld_ir    = 1'b1;
                uops.inc_pc   = 1'b1;
                uops.ld_ar_ir = 1'b1;
                state_nxt     = ctrl_pkg::EXEC;
            end
            ctrl_pkg::EXEC: begin
                state_nxt = ctrl_pkg::FETCH;
                case (op)
                    isa_pkg::LDA, isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND_OP: begin
                        // read issued here, AC loads next cycle
                        uops.ld_dr = 1'b1;
                        state_nxt  = ctrl_pkg::WRITEBACK;
                    end
                    isa_pkg::STA: begin
                        uops.wr_mem = 1'b1;
                    end
                    isa_pkg::LDI, isa_pkg::ADI: begin
                        uops.ld_ac   = 1'b1;
                        uops.use_imm = 1'b1;
                    end
                    isa_pkg::JMP: begin
                        uops.ld_pc_ir = 1'b1;
                    end
                    isa_pkg::JZ: begin
                        uops.ld_pc_ir = zero;
                    end
                    isa_pkg::HLT: begin
                        state_nxt = ctrl_pkg::HALT;
                    end
                    default: begin
                    end
                endcase
            end
            ctrl_pkg::WRITEBACK: begin
                uops.ld_ac = 1'b1;
                state_nxt  = ctrl_pkg::FETCH;
            end
            default: begin
                state_nxt = ctrl_pkg::IDLE;
            end
        endcase
    end

    // start only comes while the core waits in IDLE or HALT
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy
    ) else $error("start pulsed while core busy");

endmodule

/* rtl/core.sv */
`timescale 1ns/10ps

module core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  isa_pkg::word_t      imem_rdata,
    input  isa_pkg::word_t      dmem_rdata,
    output isa_pkg::word_t      imem_addr,
    output ctrl_pkg::dmem_req_t dmem_req,
    output logic                busy,
    output logic                done
);

    ctrl_pkg::micro_ops_t uops;
    isa_pkg::instr_u      instr;
    logic                 zero;
    logic                 clear;

    control_unit i_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .instr (instr),
        .zero  (zero),
        .uops  (uops),
        .clear (clear),
        .busy  (busy),
        .done  (done)
    );

    datapath i_dp (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .uops       (uops),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_req   (dmem_req),
        .instr      (instr),
        .zero       (zero)
    );

endmodule

/* rtl/top.sv */
`timescale 1ns/10ps

module top #(
    parameter int IMEM_AW = 8,
    parameter int DMEM_AW = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  ctrl_pkg::host_wr_t host_wr,
    input  isa_pkg::word_t     host_rd_addr,
    output isa_pkg::word_t     host_rd_data,
    output logic               busy,
    output logic               done
);

    isa_pkg::word_t      imem_addr;
    isa_pkg::word_t      imem_rdata;
    isa_pkg::word_t      dmem_rdata;
    ctrl_pkg::dmem_req_t dmem_req;

    core i_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_req   (dmem_req),
        .busy       (busy),
        .done       (done)
    );

    instruction_memory #(.IMEM_AW(IMEM_AW)) i_imem (
        .clk     (clk),
        .busy    (busy),
        .host_wr (host_wr),
        .addr    (imem_addr),
        .rdata   (imem_rdata)
    );

    data_memory #(.DMEM_AW(DMEM_AW)) i_dmem (
        .clk          (clk),
        .busy         (busy),
        .core_req     (dmem_req),
        .host_wr      (host_wr),
        .host_rd_addr (host_rd_addr),
        .rdata        (dmem_rdata)
    );

    // core and host share the read register
    assign host_rd_data = dmem_rdata;

endmodule

/* dv/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
    parameter int HALF_NS      = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_NS) clk = ~clk;
        end
    end

    // release lands between edges, like the other testbench drives
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

    localparam int IMEM_AW      = 8;
    localparam int DMEM_AW      = 8;
    localparam int NUM_PROGRAMS = 4;
    localparam int PROG_CYCLES  = 400;
    localparam int CLK_NS       = 20;
    localparam int MODEL_STEPS  = 1000;

    logic               clk;
    logic               rst_n;
    logic               start;
    ctrl_pkg::host_wr_t host_wr;
    isa_pkg::word_t     host_rd_addr;
    isa_pkg::word_t     host_rd_data;
    logic               busy;
    logic               done;

    isa_pkg::word_t     prog_img [2**IMEM_AW];
    isa_pkg::word_t     exp_mem [2**DMEM_AW];
    int                 prog_len;
    logic [DMEM_AW-1:0] track_q [$];
    logic               compare_req;
    logic [31:0]        rng_state   = 32'h2e1bbd11;
    int                 check_count = 0;
    int                 error_count = 0;

    clock_gen i_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    top #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .host_wr      (host_wr),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (host_rd_data),
        .busy         (busy),
        .done         (done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic isa_pkg::word_t rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    function automatic isa_pkg::word_t encode(input isa_pkg::opcode_e op, input logic [11:0] fld);
        return {op, fld};
    endfunction

    // ISA level model, runs prog_img against exp_mem in place
    // returns the instruction count, or -1 when HLT is never reached
    function automatic int model_run();
        isa_pkg::word_t     ac;
        isa_pkg::word_t     pc;
        isa_pkg::word_t     ir;
        isa_pkg::word_t     sx;
        logic [11:0]        fld;
        logic [DMEM_AW-1:0] da;
        ac = '0;
        pc = '0;
        for (int steps = 1; steps <= MODEL_STEPS; steps++) begin
            ir  = prog_img[pc[IMEM_AW-1:0]];
            pc  = pc + 16'd1;
            fld = ir[11:0];
            sx  = {{4{fld[11]}}, fld};
            da  = fld[DMEM_AW-1:0];
            case (ir[15:12])
                isa_pkg::LDA:    ac = exp_mem[da];
                isa_pkg::STA:    exp_mem[da] = ac;
                isa_pkg::ADD:    ac = ac + exp_mem[da];
                isa_pkg::SUB:    ac = ac - exp_mem[da];
                isa_pkg::AND_OP: ac = ac & exp_mem[da];
                isa_pkg::LDI:    ac = sx;
                isa_pkg::ADI:    ac = ac + sx;
                isa_pkg::JMP:    pc = {4'h0, fld};
                isa_pkg::JZ: begin
                    if (ac == '0) begin
                        pc = {4'h0, fld};
                    end
                end
                isa_pkg::HLT:    return steps;
                default: begin
                end
            endcase
        end
        return -1;
    endfunction

    task automatic report_and_finish();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    // all host tasks begin and end 2 ns after a rising edge
    task automatic host_write(input logic imem, input isa_pkg::word_t addr,
                              input isa_pkg::word_t data);
        host_wr.imem_sel = imem;
        host_wr.we       = 1'b1;
        host_wr.addr     = addr;
        host_wr.data     = data;
        @(posedge clk);
        #2;
        host_wr.we = 1'b0;
    endtask

    task automatic load_data(input logic [DMEM_AW-1:0] a, input isa_pkg::word_t v);
        host_write(1'b0, 16'(a), v);
        exp_mem[a] = v;
    endtask

    task automatic clear_program();
        prog_len = 0;
        for (int i = 0; i < 2**IMEM_AW; i++) begin
            prog_img[i] = encode(isa_pkg::HLT, 12'h000);
        end
    endtask

    task automatic emit(input isa_pkg::word_t w);
        prog_img[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_tracked();
        compare_req = 1'b1;
        wait (compare_req === 1'b0);
    endtask

    task automatic start_program();
        int steps;
        steps = model_run();
        assert (steps > 0) else begin
            $display("reference model did not reach HLT within %0d steps", MODEL_STEPS);
            error_count++;
        end
        for (int i = 0; i < prog_len; i++) begin
            host_write(1'b1, 16'(i), prog_img[i]);
        end
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        check_count++;
        assert (busy === 1'b1 && done === 1'b0) else begin
            $display("ERROR: busy/done after start are %h/%h, expected 1/0", busy, done);
            error_count++;
        end
    endtask

    task automatic finish_program();
        while (done !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        check_count++;
        assert (busy === 1'b0) else begin
            $display("ERROR: busy is %h while done is high, expected 0", busy);
            error_count++;
        end
        check_tracked();
    endtask

    // readback of every tracked address against the model
    initial begin : compare_proc
        logic [DMEM_AW-1:0] a;
        compare_req  = 1'b0;
        host_rd_addr = '0;
        forever begin
            wait (compare_req === 1'b1);
            while (track_q.size() > 0) begin
                a            = track_q.pop_front();
                host_rd_addr = 16'(a);
                @(posedge clk);
                #2;
                check_count++;
                assert (host_rd_data === exp_mem[a]) else begin
                    $display("ERROR: host_rd_data at %h is %h, expected %h",
                             a, host_rd_data, exp_mem[a]);
                    error_count++;
                end
            end
            compare_req = 1'b0;
        end
    end

    initial begin : watchdog
        #(NUM_PROGRAMS * PROG_CYCLES * CLK_NS);
        $display("watchdog expired, the run did not finish in time");
        error_count++;
        report_and_finish();
    end

    initial begin : main_seq
        isa_pkg::word_t v;
        int             n;
        start   = 1'b0;
        host_wr = '0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #2;

        // idle after reset, plain host write and readback
        check_count++;
        assert (busy === 1'b0 && done === 1'b0) else begin
            $display("ERROR: busy/done after reset are %h/%h, expected 0/0", busy, done);
            error_count++;
        end
        for (int a = 5; a < 8; a++) begin
            load_data(8'(a), rand_word());
            track_q.push_back(8'(a));
        end
        load_data(8'hfe, 16'h1234);
        track_q.push_back(8'hfe);
        check_tracked();

        // memory operands, both addends negative so the sum wraps
        load_data(8'h10, rand_word() | 16'h8000);
        load_data(8'h11, rand_word() | 16'h8000);
        load_data(8'h12, rand_word());
        load_data(8'h13, rand_word());
        clear_program();
        emit(encode(isa_pkg::LDA, 12'h010));
        emit(encode(isa_pkg::ADD, 12'h011));
        emit(encode(isa_pkg::STA, 12'h020));
        emit(encode(isa_pkg::SUB, 12'h012));
        emit(encode(isa_pkg::STA, 12'h021));
        emit(encode(isa_pkg::AND_OP, 12'h013));
        emit(encode(isa_pkg::STA, 12'h022));
        emit(encode(isa_pkg::LDA, 12'h011));
        emit(encode(isa_pkg::ADD, 12'h011));
        emit(encode(isa_pkg::STA, 12'h023));
        emit(encode(isa_pkg::HLT, 12'h000));
        for (int a = 8'h20; a < 8'h24; a++) begin
            track_q.push_back(8'(a));
        end
        start_program();
        finish_program();

        // negative immediates
        v = rand_word();
        clear_program();
        emit(encode(isa_pkg::LDI, 12'hffb));
        emit(encode(isa_pkg::STA, 12'h030));
        emit(encode(isa_pkg::ADI, 12'hed4));
        emit(encode(isa_pkg::STA, 12'h031));
        emit(encode(isa_pkg::LDI, 12'h800));
        emit(encode(isa_pkg::ADI, 12'hfff));
        emit(encode(isa_pkg::STA, 12'h032));
        emit(encode(isa_pkg::LDI, v[11:0]));
        emit(encode(isa_pkg::ADI, v[15:4]));
        emit(encode(isa_pkg::STA, 12'h033));
        emit(encode(isa_pkg::HLT, 12'h000));
        for (int a = 8'h30; a < 8'h34; a++) begin
            track_q.push_back(8'(a));
        end
        start_program();
        finish_program();

        // countdown loop, with host writes made while busy
        n = 2 + (rand_word() % 8);
        load_data(8'h40, 16'(n));
        load_data(8'h41, 16'h0001);
        load_data(8'h42, 16'h0000);
        load_data(8'h50, 16'h0f0f);
        clear_program();
        emit(encode(isa_pkg::LDA, 12'h040));
        emit(encode(isa_pkg::JZ, 12'h008));
        emit(encode(isa_pkg::SUB, 12'h041));
        emit(encode(isa_pkg::STA, 12'h040));
        emit(encode(isa_pkg::LDA, 12'h042));
        emit(encode(isa_pkg::ADD, 12'h041));
        emit(encode(isa_pkg::STA, 12'h042));
        emit(encode(isa_pkg::JMP, 12'h000));
        emit(encode(isa_pkg::LDI, 12'h05a));
        emit(encode(isa_pkg::STA, 12'h043));
        emit(encode(isa_pkg::HLT, 12'h000));
        track_q.push_back(8'h40);
        track_q.push_back(8'h42);
        track_q.push_back(8'h43);
        track_q.push_back(8'h50);
        start_program();
        host_write(1'b0, 16'h0050, 16'hdead);
        host_write(1'b0, 16'h0042, 16'hbeef);
        finish_program();

        // restart from HALT, AC and zero flag cleared by start
        load_data(8'h60, 16'hffff);
        clear_program();
        emit(encode(isa_pkg::JZ, 12'h002));
        emit(encode(isa_pkg::HLT, 12'h000));
        emit(encode(isa_pkg::ADI, 12'h003));
        emit(encode(isa_pkg::STA, 12'h060));
        emit(encode(isa_pkg::HLT, 12'h000));
        track_q.push_back(8'h60);
        start_program();
        finish_program();

        report_and_finish();
    end

endmodule

/* sim.f */
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/alu.sv
rtl/instruction_memory.sv
rtl/data_memory.sv
rtl/datapath.sv
rtl/control_unit.sv
rtl/core.sv
rtl/top.sv
dv/clock_gen.sv
dv/tb_top.sv
